//--- verilog/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // Tick lengths, shortened for simulation
  localparam int TICKS_PER_MS = 10;  // clk cycles per ms tick
  localparam int LED_DIV_MS   = 8;   // ms ticks per LED tick
  localparam int CW_DELAY_MS  = 4;   // CW delay line depth

  localparam int MS_CNT_W  = $clog2(TICKS_PER_MS);
  localparam int LED_CNT_W = $clog2(LED_DIV_MS);

  localparam logic [MS_CNT_W-1:0]  MS_LAST  = MS_CNT_W'(TICKS_PER_MS - 1);
  localparam logic [LED_CNT_W-1:0] LED_LAST = LED_CNT_W'(LED_DIV_MS - 1);

  // Minimum power hold after key down, in ms
  localparam logic [9:0] KEY_UP_TIMEOUT = 10'd6;
  localparam int         HANG_W         = 10;

  // Command addresses
  localparam logic [5:0] ADDR_MODE   = 6'h09;
  localparam logic [5:0] ADDR_CWHANG = 6'h10;

  // Mode bits in the command data
  localparam int VNA_BIT    = 23;
  localparam int PA_EN_BIT  = 19;
  localparam int TR_DIS_BIT = 18;

  // Telemetry widths and slot 0 id byte
  localparam int         TELEM_W   = 12;
  localparam int         SERIAL_W  = 8;
  localparam logic [7:0] STATUS_ID = 8'h1E;

  typedef enum logic [1:0] {
    CLR   = 2'b00,
    SET   = 2'b01,
    WAIT1 = 2'b10,
    WAIT2 = 2'b11
  } led_state_e;

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    PENDING = 2'b01
  } resp_state_e;

  typedef struct packed {
    logic        valid;
    logic [5:0]  addr;
    logic        tx_on;
    logic [31:0] data;
  } cmd_echo_t;

  typedef struct packed {
    logic [2:0]  zero;
    logic [1:0]  slot;
    logic        zero1;
    logic        cwkey;
    logic        ptt;
    logic [31:0] payload;
  } status_t;

  // One 40-bit response word, read as echo or as status
  typedef union packed {
    cmd_echo_t cmd_echo;
    status_t   status;
  } resp_word_u;

endpackage

`default_nettype wire

//--- verilog/cmd_if.sv
`default_nettype none

interface cmd_if (
  input wire clk
);
  logic        cmd_rqst;           // One-cycle strobe
  logic [5:0]  cmd_addr;           // Valid with cmd_rqst
  logic [31:0] cmd_data;
  logic        cmd_requires_resp;
  logic        cmd_ptt;

  modport src (input clk, output cmd_rqst, cmd_addr, cmd_data, cmd_requires_resp, cmd_ptt);
  modport sink (input clk, cmd_rqst, cmd_addr, cmd_data, cmd_requires_resp, cmd_ptt);

endinterface

`default_nettype wire

//--- verilog/tick_timer.sv
`default_nettype none

module tick_timer (
  input  wire  clk,
  input  wire  rst_n_i,
  output logic ms_tick_o,
  output logic led_tick_o
);

  logic [ctrl_pkg::MS_CNT_W-1:0]  ms_cnt_q;
  logic [ctrl_pkg::LED_CNT_W-1:0] led_cnt_q;
  logic                           ms_wrap;

  assign ms_wrap = (ms_cnt_q == ctrl_pkg::MS_LAST);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ms_cnt_q   <= '0;
      led_cnt_q  <= '0;
      ms_tick_o  <= 1'b0;
      led_tick_o <= 1'b0;
    end else begin
      ms_tick_o  <= ms_wrap;
      led_tick_o <= 1'b0;
      if (ms_wrap) begin
        ms_cnt_q <= '0;
        // LED tick lands on the same cycle as its ms tick
        if (led_cnt_q == ctrl_pkg::LED_LAST) begin
          led_cnt_q  <= '0;
          led_tick_o <= 1'b1;
        end else begin
          led_cnt_q <= led_cnt_q + 1'b1;
        end
      end else begin
        ms_cnt_q <= ms_cnt_q + 1'b1;
      end
    end
  end

  a_led_in_ms: assert property (@(posedge clk) disable iff (!rst_n_i)
    led_tick_o |-> ms_tick_o);

endmodule

`default_nettype wire

//--- verilog/cmd_regs.sv
`default_nettype none

module cmd_regs (
  input  wire                          clk,
  input  wire                          rst_n_i,
  cmd_if.sink                          cmd,
  output logic                         vna_o,
  output logic                         pa_enable_o,
  output logic                         tr_disable_o,
  output logic [ctrl_pkg::HANG_W-1:0]  cw_hang_time_o,
  output logic                         int_ptt_o
);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vna_o          <= 1'b0;
      pa_enable_o    <= 1'b0;
      tr_disable_o   <= 1'b0;
      cw_hang_time_o <= '0;
      int_ptt_o      <= 1'b0;
    end else if (cmd.cmd_rqst) begin
      int_ptt_o <= cmd.cmd_ptt;  // Every command carries PTT
      if (cmd.cmd_addr == ctrl_pkg::ADDR_MODE) begin
        vna_o        <= cmd.cmd_data[ctrl_pkg::VNA_BIT];
        pa_enable_o  <= cmd.cmd_data[ctrl_pkg::PA_EN_BIT];
        tr_disable_o <= cmd.cmd_data[ctrl_pkg::TR_DIS_BIT];
      end else if (cmd.cmd_addr == ctrl_pkg::ADDR_CWHANG) begin
        // Hang time split across two fields of the data word
        cw_hang_time_o <= {cmd.cmd_data[31:24], cmd.cmd_data[17:16]};
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/led_flash.sv
`default_nettype none

module led_flash (
  input  wire  clk,
  input  wire  rst_n_i,
  input  wire  led_tick_i,
  input  wire  sig_i,
  output logic led_o
);

  ctrl_pkg::led_state_e state_q;
  ctrl_pkg::led_state_e state_d;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ctrl_pkg::CLR;
    end else begin
      state_q <= state_d;
    end
  end

  // Lit for two to three LED ticks per event
  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::CLR: begin
        if (sig_i) state_d = ctrl_pkg::SET;
      end
      ctrl_pkg::SET: begin
        if (led_tick_i) state_d = ctrl_pkg::WAIT1;
      end
      ctrl_pkg::WAIT1: begin
        if (led_tick_i) state_d = ctrl_pkg::WAIT2;
      end
      ctrl_pkg::WAIT2: begin
        if (led_tick_i) state_d = ctrl_pkg::CLR;
      end
      default: state_d = ctrl_pkg::CLR;
    endcase
  end

  assign led_o = (state_q == ctrl_pkg::CLR);  // High is off

  a_clr_exit: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q == ctrl_pkg::CLR && !sig_i) |=> state_q == ctrl_pkg::CLR);

endmodule

`default_nettype wire

//--- verilog/tx_sequencer.sv
`default_nettype none

module tx_sequencer (
  input  wire                          clk,
  input  wire                          rst_n_i,
  input  wire                          ms_tick_i,
  input  wire                          run_i,
  input  wire                          int_ptt_i,
  input  wire                          ext_ptt_i,
  input  wire                          ext_txinhibit_i,
  input  wire                          cw_key_i,
  input  wire                          vna_i,
  input  wire                          pa_enable_i,
  input  wire                          tr_disable_i,
  input  wire [ctrl_pkg::HANG_W-1:0]   cw_hang_time_i,
  output logic                         tx_on_o,
  output logic                         cw_keydown_o,
  output logic                         pa_tr_o,
  output logic                         pa_en_o,
  output logic                         pwr_envpa_o
);

  logic [ctrl_pkg::CW_DELAY_MS-1:0] cw_dly_q;      // One stage per ms
  logic [ctrl_pkg::HANG_W-1:0]      pwr_timeout_q;
  logic                             hang_phase_q;  // Second count runs the hang time
  logic                             cw_pwr_on_q;
  logic                             pwr_on;

  assign tx_on_o = (int_ptt_i | cw_keydown_o | ext_ptt_i) & ~ext_txinhibit_i & run_i;

  // Delay the key so the relay and PA settle before RF
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cw_dly_q <= '0;
    end else if (ms_tick_i) begin
      cw_dly_q <= {cw_dly_q[ctrl_pkg::CW_DELAY_MS-2:0], cw_key_i};
    end
  end

  assign cw_keydown_o = cw_dly_q[ctrl_pkg::CW_DELAY_MS-1];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pwr_timeout_q <= '0;
      hang_phase_q  <= 1'b0;
      cw_pwr_on_q   <= 1'b0;
    end else if (cw_key_i) begin
      pwr_timeout_q <= ctrl_pkg::KEY_UP_TIMEOUT;  // Restart on every key down
      hang_phase_q  <= 1'b0;
      cw_pwr_on_q   <= 1'b1;
    end else if (ms_tick_i) begin
      if (pwr_timeout_q != '0) begin
        pwr_timeout_q <= pwr_timeout_q - 1'b1;
      end else if (!hang_phase_q) begin
        pwr_timeout_q <= cw_hang_time_i;
        hang_phase_q  <= 1'b1;
      end else begin
        cw_pwr_on_q <= 1'b0;
      end
    end
  end

  assign pwr_on = cw_pwr_on_q | tx_on_o;

  assign pa_tr_o     = pwr_on & ~vna_i & (pa_enable_i | ~tr_disable_i);
  assign pa_en_o     = pwr_on & ~vna_i & pa_enable_i;
  assign pwr_envpa_o = pwr_on;

endmodule

`default_nettype wire

//--- verilog/resp_fsm.sv
`default_nettype none

module resp_fsm (
  input  wire                            clk,
  input  wire                            rst_n_i,
  cmd_if.sink                            cmd,
  input  wire                            resp_rqst_i,
  input  wire                            tx_on_i,
  input  wire                            rxclip_i,
  input  wire                            ext_cwkey_i,
  input  wire                            ext_ptt_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]    temperature_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]    fwd_pwr_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]    rev_pwr_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]    bias_current_i,
  input  wire [ctrl_pkg::SERIAL_W-1:0]   serialno_i,
  output ctrl_pkg::resp_word_u           resp_o
);

  localparam int PAD_W = 16 - ctrl_pkg::TELEM_W;

  ctrl_pkg::resp_state_e state_q;
  ctrl_pkg::resp_state_e state_d;
  logic                  capture;
  logic                  cmd_new;
  logic [5:0]            pend_addr_q;
  logic [31:0]           pend_data_q;
  logic [1:0]            slot_q;
  logic [1:0]            clip_cnt_q;
  logic                  clip_sat;
  logic                  loaded_q;     // Set after the first response load
  ctrl_pkg::resp_word_u  resp_q;
  ctrl_pkg::resp_word_u  status_w;
  ctrl_pkg::resp_word_u  echo_w;

  assign cmd_new  = cmd.cmd_rqst & cmd.cmd_requires_resp;
  assign clip_sat = &clip_cnt_q;

  // Queue of one; a newer command replaces the pending one
  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    case (state_q)
      ctrl_pkg::IDLE: begin
        if (cmd_new) begin
          capture = 1'b1;
          state_d = ctrl_pkg::PENDING;
        end
      end
      ctrl_pkg::PENDING: begin
        if (cmd_new) begin
          capture = 1'b1;
        end else if (resp_rqst_i) begin
          state_d = ctrl_pkg::IDLE;
        end
      end
      default: state_d = ctrl_pkg::IDLE;
    endcase
  end

  always_comb begin
    status_w              = '0;
    status_w.status.slot  = slot_q;
    status_w.status.cwkey = ext_cwkey_i;
    status_w.status.ptt   = ext_ptt_i;
    case (slot_q)
      2'd0: status_w.status.payload = {ctrl_pkg::STATUS_ID | {7'd0, clip_sat}, 16'h0000,
                                       serialno_i};
      2'd1: status_w.status.payload = {{PAD_W{1'b0}}, temperature_i, {PAD_W{1'b0}}, fwd_pwr_i};
      2'd2: status_w.status.payload = {{PAD_W{1'b0}}, rev_pwr_i, {PAD_W{1'b0}}, bias_current_i};
      default: status_w.status.payload = '0;  // Spare slot
    endcase
  end

  always_comb begin
    echo_w.cmd_echo.valid = 1'b1;
    echo_w.cmd_echo.addr  = pend_addr_q;
    echo_w.cmd_echo.tx_on = tx_on_i;
    echo_w.cmd_echo.data  = pend_data_q;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ctrl_pkg::IDLE;
      slot_q     <= 2'd0;
      clip_cnt_q <= 2'd0;
      loaded_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (resp_rqst_i) begin
        slot_q     <= slot_q + 2'd1;  // Echo also uses up a slot
        clip_cnt_q <= 2'd0;
        loaded_q   <= 1'b1;
      end else if (!clip_sat) begin
        clip_cnt_q <= clip_cnt_q + {1'b0, rxclip_i};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      pend_addr_q <= cmd.cmd_addr;
      pend_data_q <= cmd.cmd_data;
    end
    if (resp_rqst_i) begin
      resp_q <= (state_q == ctrl_pkg::PENDING) ? echo_w : status_w;
    end
  end

  assign resp_o = loaded_q ? resp_q : status_w;  // Slot 0 status until first request

  a_state_ok: assert property (@(posedge clk) disable iff (!rst_n_i)
    state_q inside {ctrl_pkg::IDLE, ctrl_pkg::PENDING});

endmodule

`default_nettype wire

//--- verilog/radio_ctrl.sv
`default_nettype none

module radio_ctrl (
  input  wire                           clk,
  input  wire                           rst_n_i,
  input  wire                           cmd_rqst_i,
  input  wire [5:0]                     cmd_addr_i,
  input  wire [31:0]                    cmd_data_i,
  input  wire                           cmd_requires_resp_i,
  input  wire                           cmd_ptt_i,
  input  wire                           resp_rqst_i,
  input  wire                           run_i,
  input  wire                           ext_ptt_i,
  input  wire                           ext_txinhibit_i,
  input  wire                           cw_key_i,
  input  wire                           rxclip_i,
  input  wire                           rxgoodlvl_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]   temperature_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]   fwd_pwr_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]   rev_pwr_i,
  input  wire [ctrl_pkg::TELEM_W-1:0]   bias_current_i,
  input  wire [ctrl_pkg::SERIAL_W-1:0]  serialno_i,
  output logic [39:0]                   resp_o,
  output logic                          tx_on_o,
  output logic                          cw_keydown_o,
  output logic                          pa_tr_o,
  output logic                          pa_en_o,
  output logic                          pwr_envpa_o,
  output logic                          rffe_rfsw_sel_o,
  output logic                          led_rx_o,
  output logic                          led_clip_o
);

  logic                        ms_tick;
  logic                        led_tick;
  logic                        vna;
  logic                        pa_enable;
  logic                        tr_disable;
  logic [ctrl_pkg::HANG_W-1:0] cw_hang_time;
  logic                        int_ptt;
  logic                        led_rx_flash;
  logic                        led_clip_flash;

  cmd_if u_cmd_if (.clk(clk));

  assign u_cmd_if.cmd_rqst          = cmd_rqst_i;
  assign u_cmd_if.cmd_addr          = cmd_addr_i;
  assign u_cmd_if.cmd_data          = cmd_data_i;
  assign u_cmd_if.cmd_requires_resp = cmd_requires_resp_i;
  assign u_cmd_if.cmd_ptt           = cmd_ptt_i;

  tick_timer u_tick_timer (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .ms_tick_o (ms_tick),
    .led_tick_o(led_tick)
  );

  cmd_regs u_cmd_regs (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .cmd           (u_cmd_if.sink),
    .vna_o         (vna),
    .pa_enable_o   (pa_enable),
    .tr_disable_o  (tr_disable),
    .cw_hang_time_o(cw_hang_time),
    .int_ptt_o     (int_ptt)
  );

  led_flash u_led_rx (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .led_tick_i(led_tick),
    .sig_i     (rxgoodlvl_i),
    .led_o     (led_rx_flash)
  );

  led_flash u_led_clip (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .led_tick_i(led_tick),
    .sig_i     (rxclip_i),
    .led_o     (led_clip_flash)
  );

  tx_sequencer u_tx_sequencer (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ms_tick_i      (ms_tick),
    .run_i          (run_i),
    .int_ptt_i      (int_ptt),
    .ext_ptt_i      (ext_ptt_i),
    .ext_txinhibit_i(ext_txinhibit_i),
    .cw_key_i       (cw_key_i),
    .vna_i          (vna),
    .pa_enable_i    (pa_enable),
    .tr_disable_i   (tr_disable),
    .cw_hang_time_i (cw_hang_time),
    .tx_on_o        (tx_on_o),
    .cw_keydown_o   (cw_keydown_o),
    .pa_tr_o        (pa_tr_o),
    .pa_en_o        (pa_en_o),
    .pwr_envpa_o    (pwr_envpa_o)
  );

  resp_fsm u_resp_fsm (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .cmd           (u_cmd_if.sink),
    .resp_rqst_i   (resp_rqst_i),
    .tx_on_i       (tx_on_o),
    .rxclip_i      (rxclip_i),
    .ext_cwkey_i   (cw_key_i),
    .ext_ptt_i     (ext_ptt_i),
    .temperature_i (temperature_i),
    .fwd_pwr_i     (fwd_pwr_i),
    .rev_pwr_i     (rev_pwr_i),
    .bias_current_i(bias_current_i),
    .serialno_i    (serialno_i),
    .resp_o        (resp_o)
  );

  // LEDs dark while the host is not running
  assign led_rx_o   = run_i ? led_rx_flash : 1'b1;
  assign led_clip_o = run_i ? led_clip_flash : 1'b1;

  assign rffe_rfsw_sel_o = ~vna & pa_enable;

endmodule

`default_nettype wire

//--- tests/radio_ctrl_tb.sv
`default_nettype none

module radio_ctrl_tb;

  localparam int NUM_ROWS = 10;
  localparam int HANG_MS  = 5;                                 // Hang time set by the table
  localparam int MS_CYC   = ctrl_pkg::TICKS_PER_MS;
  localparam int LED_CYC  = ctrl_pkg::LED_DIV_MS * MS_CYC;
  localparam int CASE_WIN = 40 * MS_CYC;                       // Longest case, in cycles
  localparam int WDOG_CYC = (NUM_ROWS + 4) * CASE_WIN;
  localparam int KEY_UP   = int'(ctrl_pkg::KEY_UP_TIMEOUT);

  typedef struct packed {
    logic [5:0] addr;
    logic [2:0] mode;  // vna, pa_en, tr_dis
    logic [9:0] hang;
    logic [4:0] lvl;   // requires_resp, cmd_ptt, run, ext_ptt, inhibit
    logic [4:0] expv;  // tx_on, pa_tr, pa_en, pwr_envpa, rfsw_sel
  } row_t;

  logic                          clk;
  logic                          rst_n_i;
  logic                          cmd_rqst_i;
  logic [5:0]                    cmd_addr_i;
  logic [31:0]                   cmd_data_i;
  logic                          cmd_requires_resp_i;
  logic                          cmd_ptt_i;
  logic                          resp_rqst_i;
  logic                          run_i;
  logic                          ext_ptt_i;
  logic                          ext_txinhibit_i;
  logic                          cw_key_i;
  logic                          rxclip_i;
  logic                          rxgoodlvl_i;
  logic [ctrl_pkg::TELEM_W-1:0]  temperature_i;
  logic [ctrl_pkg::TELEM_W-1:0]  fwd_pwr_i;
  logic [ctrl_pkg::TELEM_W-1:0]  rev_pwr_i;
  logic [ctrl_pkg::TELEM_W-1:0]  bias_current_i;
  logic [ctrl_pkg::SERIAL_W-1:0] serialno_i;
  logic [39:0]                   resp_o;
  logic                          tx_on_o;
  logic                          cw_keydown_o;
  logic                          pa_tr_o;
  logic                          pa_en_o;
  logic                          pwr_envpa_o;
  logic                          rffe_rfsw_sel_o;
  logic                          led_rx_o;
  logic                          led_clip_o;

  row_t                 rows [NUM_ROWS];
  ctrl_pkg::resp_word_u rw;
  logic [31:0]          rnd;
  int                   errors;
  int                   stalls;

  radio_ctrl u_radio_ctrl (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .cmd_rqst_i         (cmd_rqst_i),
    .cmd_addr_i         (cmd_addr_i),
    .cmd_data_i         (cmd_data_i),
    .cmd_requires_resp_i(cmd_requires_resp_i),
    .cmd_ptt_i          (cmd_ptt_i),
    .resp_rqst_i        (resp_rqst_i),
    .run_i              (run_i),
    .ext_ptt_i          (ext_ptt_i),
    .ext_txinhibit_i    (ext_txinhibit_i),
    .cw_key_i           (cw_key_i),
    .rxclip_i           (rxclip_i),
    .rxgoodlvl_i        (rxgoodlvl_i),
    .temperature_i      (temperature_i),
    .fwd_pwr_i          (fwd_pwr_i),
    .rev_pwr_i          (rev_pwr_i),
    .bias_current_i     (bias_current_i),
    .serialno_i         (serialno_i),
    .resp_o             (resp_o),
    .tx_on_o            (tx_on_o),
    .cw_keydown_o       (cw_keydown_o),
    .pa_tr_o            (pa_tr_o),
    .pa_en_o            (pa_en_o),
    .pwr_envpa_o        (pwr_envpa_o),
    .rffe_rfsw_sel_o    (rffe_rfsw_sel_o),
    .led_rx_o           (led_rx_o),
    .led_clip_o         (led_clip_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("Timeout: run exceeded %0d cycles with %0d value errors", WDOG_CYC, errors);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic report_stall(input string msg);
    stalls++;
    $display("Wait failed at time %0t: %s", $time, msg);
  endtask

  // Random data with the addressed fields forced
  function automatic logic [31:0] build_data(input logic [5:0] addr, input logic [2:0] mode,
                                             input logic [9:0] hang);
    logic [31:0] d;
    d = $urandom;
    if (addr == ctrl_pkg::ADDR_MODE) begin
      d[ctrl_pkg::VNA_BIT]    = mode[2];
      d[ctrl_pkg::PA_EN_BIT]  = mode[1];
      d[ctrl_pkg::TR_DIS_BIT] = mode[0];
    end else if (addr == ctrl_pkg::ADDR_CWHANG) begin
      d[31:24] = hang[9:2];
      d[17:16] = hang[1:0];
    end
    return d;
  endfunction

  function automatic logic [31:0] slot_payload(input logic [1:0] slot, input logic clip);
    case (slot)
      2'd0:    return {7'h0F, clip, 16'h0000, serialno_i};  // 0x1E with clip in bit 0
      2'd1:    return {16'(temperature_i), 16'(fwd_pwr_i)};
      2'd2:    return {16'(rev_pwr_i), 16'(bias_current_i)};
      default: return 32'h0;
    endcase
  endfunction

  task automatic check_status(input logic [1:0] slot, input logic clip, input logic ptt);
    rw = resp_o;
    if (rw.status.slot !== slot)
      report_error($sformatf("status slot %0d, expected %0d", rw.status.slot, slot));
    if ({rw.status.zero, rw.status.zero1, rw.status.cwkey, rw.status.ptt} !==
        {4'b0000, cw_key_i, ptt})
      report_error($sformatf("slot %0d flag bits wrong, ptt %b expected %b",
                             slot, rw.status.ptt, ptt));
    if (rw.status.payload !== slot_payload(slot, clip))
      report_error($sformatf("slot %0d payload %h, expected %h",
                             slot, rw.status.payload, slot_payload(slot, clip)));
  endtask

  task automatic status_rounds();
    for (int r = 0; r < 2; r++) begin
      @(posedge clk);
      rxclip_i  <= 1'b1;
      ext_ptt_i <= r[0];
      repeat (2 + r) @(posedge clk);  // 2 then 3 clip cycles
      rxclip_i <= 1'b0;
      @(negedge clk);
      if (led_clip_o !== 1'b1) report_error("led_clip lit while run is low");
      for (int s = 0; s < 4; s++) begin
        @(posedge clk) resp_rqst_i <= 1'b1;
        @(posedge clk) resp_rqst_i <= 1'b0;
        @(negedge clk);
        check_status(s[1:0], (s == 0) && (r == 1), r[0]);
      end
    end
    @(posedge clk) ext_ptt_i <= 1'b0;
  endtask

  task automatic apply_row(input row_t r, input int idx);
    logic [31:0] data;
    data = build_data(r.addr, r.mode, r.hang);
    @(posedge clk);
    cmd_rqst_i          <= 1'b1;
    cmd_addr_i          <= r.addr;
    cmd_data_i          <= data;
    cmd_requires_resp_i <= r.lvl[4];
    cmd_ptt_i           <= r.lvl[3];
    run_i               <= r.lvl[2];
    ext_ptt_i           <= r.lvl[1];
    ext_txinhibit_i     <= r.lvl[0];
    @(posedge clk);
    cmd_rqst_i          <= 1'b0;
    cmd_requires_resp_i <= 1'b0;
    @(negedge clk);
    if ({tx_on_o, pa_tr_o, pa_en_o, pwr_envpa_o, rffe_rfsw_sel_o} !== r.expv)
      report_error($sformatf("row %0d tx/pa_tr/pa_en/pwr/rfsw %b, expected %b", idx,
                             {tx_on_o, pa_tr_o, pa_en_o, pwr_envpa_o, rffe_rfsw_sel_o},
                             r.expv));
    if (r.lvl[4]) begin
      @(posedge clk) resp_rqst_i <= 1'b1;
      @(posedge clk) resp_rqst_i <= 1'b0;
      @(negedge clk);
      rw = resp_o;
      if ({rw.cmd_echo.valid, rw.cmd_echo.addr, rw.cmd_echo.tx_on} !==
          {1'b1, r.addr, r.expv[4]})
        report_error($sformatf("row %0d echo valid/addr/tx_on %b/%h/%b", idx,
                               rw.cmd_echo.valid, rw.cmd_echo.addr, rw.cmd_echo.tx_on));
      if (rw.cmd_echo.data !== data)
        report_error($sformatf("row %0d echo data %h, expected %h", idx,
                               rw.cmd_echo.data, data));
    end
  endtask

  task automatic cw_and_hold();
    int cyc;
    @(posedge clk) cw_key_i <= 1'b1;
    cyc = 1;
    @(negedge clk);
    while (cw_keydown_o !== 1'b1 && cyc < CASE_WIN) begin
      @(negedge clk);
      cyc++;
    end
    if (cw_keydown_o !== 1'b1) begin
      report_stall("cw_keydown never rose after the key went down");
    end else if (cyc < (ctrl_pkg::CW_DELAY_MS - 1) * MS_CYC ||
                 cyc > (ctrl_pkg::CW_DELAY_MS + 1) * MS_CYC) begin
      report_error($sformatf("cw_keydown delay %0d cycles", cyc));
    end
    @(posedge clk) resp_rqst_i <= 1'b1;  // Status read with the key held
    @(posedge clk) resp_rqst_i <= 1'b0;
    @(negedge clk);
    check_status(2'd2, 1'b0, 1'b0);      // Six echoes and eight reads so far
    repeat (2 * MS_CYC - 2) @(posedge clk);
    cw_key_i <= 1'b0;
    cyc = 0;
    @(negedge clk);
    while (pwr_envpa_o === 1'b1 && cyc <= CASE_WIN) begin  // Cycles of power hold
      cyc++;
      @(negedge clk);
    end
    if (pwr_envpa_o === 1'b1) begin
      report_stall("pwr_envpa stayed high after the key was released");
    end else if (cyc < KEY_UP * MS_CYC || cyc > (KEY_UP + HANG_MS + 2) * MS_CYC) begin
      report_error($sformatf("power hold %0d cycles", cyc));
    end
  endtask

  task automatic led_checks();
    int cyc;
    int lit;
    @(posedge clk);
    rxclip_i    <= 1'b1;
    rxgoodlvl_i <= 1'b1;
    @(posedge clk);
    rxclip_i    <= 1'b0;
    rxgoodlvl_i <= 1'b0;
    @(negedge clk);
    if (led_clip_o !== 1'b0) report_error("led_clip not lit one cycle after rxclip");
    if (led_rx_o !== 1'b0) report_error("led_rx not lit one cycle after rxgoodlvl");
    cyc = 0;
    lit = 0;
    while (led_clip_o === 1'b0 && cyc <= 4 * LED_CYC) begin
      cyc++;
      if (led_rx_o === 1'b0) lit++;
      @(negedge clk);
    end
    if (led_clip_o !== 1'b1) begin
      report_stall("led_clip never went dark after the flash");
    end else if (cyc < 2 * LED_CYC || cyc > 3 * LED_CYC) begin
      report_error($sformatf("led_clip flash %0d cycles", cyc));
    end
    if (led_rx_o !== 1'b1 || lit < 2 * LED_CYC || lit > 3 * LED_CYC)
      report_error($sformatf("led_rx flash %0d cycles", lit));
    // Run low masks the flash
    @(posedge clk);
    run_i       <= 1'b0;
    rxclip_i    <= 1'b1;
    rxgoodlvl_i <= 1'b1;
    @(posedge clk);
    rxclip_i    <= 1'b0;
    rxgoodlvl_i <= 1'b0;
    lit = 0;
    repeat (3 * LED_CYC) begin
      @(negedge clk);
      if (led_clip_o !== 1'b1 || led_rx_o !== 1'b1) lit++;
    end
    if (lit != 0) report_error($sformatf("LEDs lit %0d cycles with run low", lit));
  endtask

  initial begin
    rnd                 = $urandom(28);
    errors              = 0;
    stalls              = 0;
    rst_n_i             = 1'b0;
    cmd_rqst_i          = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_requires_resp_i = 1'b0;
    cmd_ptt_i           = 1'b0;
    resp_rqst_i         = 1'b0;
    run_i               = 1'b0;
    ext_ptt_i           = 1'b0;
    ext_txinhibit_i     = 1'b0;
    cw_key_i            = 1'b0;
    rxclip_i            = 1'b0;
    rxgoodlvl_i         = 1'b0;
    rnd                 = $urandom;
    temperature_i       = rnd[ctrl_pkg::TELEM_W-1:0];
    fwd_pwr_i           = rnd[16 +: ctrl_pkg::TELEM_W];
    rnd                 = $urandom;
    rev_pwr_i           = rnd[ctrl_pkg::TELEM_W-1:0];
    bias_current_i      = rnd[16 +: ctrl_pkg::TELEM_W];
    rnd                 = $urandom;
    serialno_i          = rnd[ctrl_pkg::SERIAL_W-1:0];

    rows[0] = {ctrl_pkg::ADDR_MODE, 3'b010, 10'd0, 5'b11100, 5'b11111};  // Int PTT, PA on
    rows[1] = {ctrl_pkg::ADDR_MODE, 3'b001, 10'd0, 5'b00110, 5'b10010};  // T/R disabled
    rows[2] = {ctrl_pkg::ADDR_MODE, 3'b000, 10'd0, 5'b10110, 5'b11010};
    rows[3] = {ctrl_pkg::ADDR_MODE, 3'b110, 10'd0, 5'b11100, 5'b10010};  // VNA blocks PA
    rows[4] = {ctrl_pkg::ADDR_MODE, 3'b010, 10'd0, 5'b01101, 5'b00001};  // Inhibit
    rows[5] = {ctrl_pkg::ADDR_MODE, 3'b010, 10'd0, 5'b11010, 5'b00001};  // Run low
    rows[6] = {ctrl_pkg::ADDR_MODE, 3'b011, 10'd0, 5'b00100, 5'b00001};
    rows[7] = {ctrl_pkg::ADDR_MODE, 3'b011, 10'd0, 5'b10110, 5'b11111};
    rows[8] = {ctrl_pkg::ADDR_CWHANG, 3'b000, 10'(HANG_MS), 5'b11100, 5'b11111};
    rows[9] = {6'h00, 3'b000, 10'd0, 5'b00100, 5'b00001};  // Other address, PTT only

    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    if ({pa_tr_o, pa_en_o, pwr_envpa_o, tx_on_o, cw_keydown_o} !== 5'b00000)
      report_error("transmit outputs not low after reset");
    if ({led_rx_o, led_clip_o} !== 2'b11) report_error("LEDs not off after reset");
    check_status(2'd0, 1'b0, 1'b0);

    status_rounds();
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i], i);
    end
    cw_and_hold();
    led_checks();

    $display("Closing: %0d value errors, %0d failed waits", errors, stalls);
    if (errors == 0 && stalls == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- radio_ctrl.f
verilog/ctrl_pkg.sv
verilog/cmd_if.sv
verilog/tick_timer.sv
verilog/cmd_regs.sv
verilog/led_flash.sv
verilog/tx_sequencer.sv
verilog/resp_fsm.sv
verilog/radio_ctrl.sv
tests/radio_ctrl_tb.sv

//--- Bender.yml
package:
  name: radio_ctrl

sources:
  - verilog/ctrl_pkg.sv
  - verilog/cmd_if.sv
  - verilog/tick_timer.sv
  - verilog/cmd_regs.sv
  - verilog/led_flash.sv
  - verilog/tx_sequencer.sv
  - verilog/resp_fsm.sv
  - verilog/radio_ctrl.sv
  - target: simulation
    files:
      - tests/radio_ctrl_tb.sv
